//--- flist.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_issue_reg.sv
hw/ex_stage.sv
hw/wb_regfile.sv
hw/ex_subsys_top.sv
testbench/tb_ex_subsys.sv

//--- hw/ex_alu.sv
`default_nettype none

module ex_alu #(
  parameter int DATA_W = ex_pkg::XLEN
) (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  // Shift amount width, 5 bits for a 32-bit word
  localparam int SHAMT_W = $clog2(DATA_W);

  logic               adder_sub;
  logic [DATA_W-1:0]  adder_op_b;
  logic [DATA_W:0]    adder_full;
  logic [DATA_W-1:0]  adder_result;
  logic               carry_out;
  logic               is_equal;
  logic               is_lt;
  logic               is_ltu;
  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W-1:0]  sll_result;
  logic [DATA_W-1:0]  srl_result;
  logic [DATA_W-1:0]  sra_result;

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Everything except ADD goes through as a - b
  assign adder_sub  = (operator_i != ALU_ADD);
  assign adder_op_b = adder_sub ? ~operand_b_i : operand_b_i;

  // One extra bit to keep the carry
  assign adder_full = {1'b0, operand_a_i} + {1'b0, adder_op_b}
                    + {{DATA_W{1'b0}}, adder_sub};

  assign adder_result = adder_full[DATA_W-1:0];
  assign carry_out    = adder_full[DATA_W];

  //////////////////////////////
  // Comparison flags
  //////////////////////////////

  // Zero difference means equal
  assign is_equal = (adder_result == '0);

  // No borrow out of a - b means a >= b unsigned
  assign is_ltu = ~carry_out;

  // Signs differ: a is less when a is negative
  // Signs match: sign of the difference decides
  assign is_lt = (operand_a_i[DATA_W-1] != operand_b_i[DATA_W-1]) ?
                 operand_a_i[DATA_W-1] : adder_result[DATA_W-1];

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shamt      = operand_b_i[SHAMT_W-1:0];
  assign sll_result = operand_a_i << shamt;
  assign srl_result = operand_a_i >> shamt;
  // Arithmetic right shift keeps the sign
  assign sra_result = $signed(operand_a_i) >>> shamt;

  // Comparison bit, also feeds the branch decision
  always_comb
  begin
    case (operator_i)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:  cmp_result_o = is_lt;
      ALU_GE:           cmp_result_o = ~is_lt;
      ALU_LTU, ALU_SLTU: cmp_result_o = is_ltu;
      ALU_GEU:          cmp_result_o = ~is_ltu;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb
  begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = sll_result;
      ALU_SRL:          result_o = srl_result;
      ALU_SRA:          result_o = sra_result;
      // Set-less-than and branch comparisons, zero-extended bit
      default:          result_o = {{(DATA_W-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- hw/ex_issue_reg.sv
`default_nettype none

module ex_issue_reg (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid_i,
  input  ex_pkg::alu_op_e    alu_op_i,
  input  ex_pkg::data_t      op_a_i,
  input  ex_pkg::data_t      op_b_i,
  input  ex_pkg::data_t      op_c_i,
  input  logic               mult_en_i,
  input  ex_pkg::mult_mode_e mult_mode_i,
  input  logic               csr_access_i,
  input  ex_pkg::data_t      csr_rdata_i,
  input  logic               branch_i,
  input  ex_pkg::reg_addr_t  waddr_i,
  input  logic               we_i,
  input  logic               ex_ready_i,
  output logic               valid_o,
  output ex_pkg::alu_op_e    alu_op_o,
  output ex_pkg::data_t      op_a_o,
  output ex_pkg::data_t      op_b_o,
  output ex_pkg::data_t      op_c_o,
  output logic               mult_en_o,
  output ex_pkg::mult_mode_e mult_mode_o,
  output logic               csr_access_o,
  output ex_pkg::data_t      csr_rdata_o,
  output logic               branch_o,
  output ex_pkg::reg_addr_t  waddr_o,
  output logic               we_o
);

  import ex_pkg::*;

  //////////////////////////////
  // ID/EX control
  //////////////////////////////

  // Reset leaves a NOP: ADD, no write, no branch
  always_ff @(posedge clk, negedge rst_n)
  begin : id_ex_ctrl
    if (!rst_n)
    begin
      valid_o      <= 1'b0;
      alu_op_o     <= ALU_ADD;
      mult_en_o    <= 1'b0;
      csr_access_o <= 1'b0;
      branch_o     <= 1'b0;
      we_o         <= 1'b0;
    end
    else if (ex_ready_i)
    begin
      valid_o      <= in_valid_i;
      alu_op_o     <= alu_op_i;
      mult_en_o    <= mult_en_i;
      csr_access_o <= csr_access_i;
      // Bubble: no write and no branch
      branch_o     <= in_valid_i & branch_i;
      we_o         <= in_valid_i & we_i;
    end
  end

  // Operands follow only a real operation
  always_ff @(posedge clk)
  begin : id_ex_data
    if (ex_ready_i && in_valid_i)
    begin
      op_a_o      <= op_a_i;
      op_b_o      <= op_b_i;
      op_c_o      <= op_c_i;
      mult_mode_o <= mult_mode_i;
      csr_rdata_o <= csr_rdata_i;
      waddr_o     <= waddr_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/ex_mult.sv
`default_nettype none

module ex_mult #(
  parameter int DATA_W = ex_pkg::XLEN
) (
  input  ex_pkg::mult_mode_e mode_i,
  input  ex_pkg::data_t      op_a_i,
  input  ex_pkg::data_t      op_b_i,
  input  ex_pkg::data_t      mac_i,
  output ex_pkg::data_t      result_o
);

  import ex_pkg::*;

  // Operands split in halves, only the low word is kept
  localparam int HALF_W = DATA_W / 2;

  logic [HALF_W-1:0] a_lo;
  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] b_lo;
  logic [HALF_W-1:0] b_hi;
  logic [DATA_W-1:0] pp_ll;
  logic [HALF_W-1:0] pp_cross;
  logic [DATA_W-1:0] prod_lo;
  logic [DATA_W-1:0] acc;

  //////////////////////////////
  // Partial products
  //////////////////////////////

  assign a_lo = op_a_i[HALF_W-1:0];
  assign a_hi = op_a_i[DATA_W-1:HALF_W];
  assign b_lo = op_b_i[HALF_W-1:0];
  assign b_hi = op_b_i[DATA_W-1:HALF_W];

  // Low x low, full width
  assign pp_ll = {{HALF_W{1'b0}}, a_lo} * {{HALF_W{1'b0}}, b_lo};

  // Cross terms land in the upper half
  // hi x hi falls out of the low word entirely
  assign pp_cross = a_lo * b_hi + a_hi * b_lo;

  assign prod_lo = pp_ll + {pp_cross, {HALF_W{1'b0}}};

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  // Accumulator only in MAC mode
  assign acc = (mode_i == MULT_MAC) ? mac_i : '0;

  // Wraps at the word width, like the plain product
  assign result_o = prod_lo + acc;

endmodule

`default_nettype wire

//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Native word width, modules follow it by default
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Register file depth, x0 included
  localparam int NUM_REGS   = 32;

  // Operand or result word
  typedef logic [XLEN-1:0]       data_t;
  // Register file index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Operators
  //////////////////////////////

  // ALU operator, full 4-bit space in use
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier mode, low word only
  typedef enum logic {
    MULT_MUL = 1'b0,
    MULT_MAC = 1'b1
  } mult_mode_e;

endpackage

`default_nettype wire

//--- hw/ex_stage.sv
`default_nettype none

module ex_stage #(
  parameter int DATA_W = ex_pkg::XLEN
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  ex_pkg::alu_op_e    alu_op_i,
  input  ex_pkg::data_t      op_a_i,
  input  ex_pkg::data_t      op_b_i,
  input  ex_pkg::data_t      op_c_i,
  input  logic               mult_en_i,
  input  ex_pkg::mult_mode_e mult_mode_i,
  input  logic               csr_access_i,
  input  ex_pkg::data_t      csr_rdata_i,
  input  logic               branch_i,
  input  ex_pkg::reg_addr_t  waddr_i,
  input  logic               we_i,
  input  logic               lsu_ready_i,
  input  logic               wb_ready_i,
  output ex_pkg::data_t      fw_wdata_o,
  output ex_pkg::reg_addr_t  fw_waddr_o,
  output logic               fw_we_o,
  output ex_pkg::data_t      jump_target_o,
  output logic               branch_decision_o,
  output logic               ex_ready_o,
  output logic               ex_valid_o,
  output logic               wb_we_o,
  output ex_pkg::reg_addr_t  wb_waddr_o,
  output ex_pkg::data_t      wb_wdata_o
);

  import ex_pkg::*;

  data_t alu_result;
  data_t alu_csr_result;
  data_t mult_result;
  logic  alu_cmp_result;

  ex_alu #(.DATA_W(DATA_W)) u_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (op_a_i),
    .operand_b_i  (op_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // op_c doubles as the accumulator
  ex_mult #(.DATA_W(DATA_W)) u_mult (
    .mode_i   (mult_mode_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .mac_i    (op_c_i),
    .result_o (mult_result)
  );

  // Multiplier wins, then CSR over ALU
  assign alu_csr_result = csr_access_i ? csr_rdata_i : alu_result;
  assign fw_wdata_o     = mult_en_i ? mult_result : alu_csr_result;
  assign fw_waddr_o     = waddr_i;
  assign fw_we_o        = we_i;

  // Branch outcome and target straight from EX
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = op_c_i;

  // Branches retire here, so they never wait on WB or LSU
  assign ex_ready_o = (lsu_ready_i & wb_ready_i) | branch_i;
  assign ex_valid_o = lsu_ready_i & wb_ready_i;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : ex_wb_ctrl
    if (!rst_n)
    begin
      wb_we_o    <= 1'b0;
      wb_waddr_o <= '0;
    end
    else if (ex_valid_o && valid_i)
    begin
      wb_we_o <= we_i;
      if (we_i)
        wb_waddr_o <= waddr_i;
    end
    else if (wb_ready_i)
    begin
      // WB can take one but EX has none, flush
      wb_we_o <= 1'b0;
    end
  end

  // Result word only moves on a real write
  always_ff @(posedge clk)
  begin : ex_wb_data
    if (ex_valid_o && valid_i && we_i)
      wb_wdata_o <= fw_wdata_o;
  end

endmodule

`default_nettype wire

//--- hw/ex_subsys_top.sv
`default_nettype none

module ex_subsys_top #(
  parameter int DATA_W = ex_pkg::XLEN
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid_i,
  input  ex_pkg::alu_op_e    alu_op_i,
  input  ex_pkg::data_t      op_a_i,
  input  ex_pkg::data_t      op_b_i,
  input  ex_pkg::data_t      op_c_i,
  input  logic               mult_en_i,
  input  ex_pkg::mult_mode_e mult_mode_i,
  input  logic               csr_access_i,
  input  ex_pkg::data_t      csr_rdata_i,
  input  logic               branch_i,
  input  ex_pkg::reg_addr_t  waddr_i,
  input  logic               we_i,
  input  logic               lsu_ready_i,
  input  logic               wb_ready_i,
  input  ex_pkg::reg_addr_t  rd_addr_i,
  output ex_pkg::data_t      fw_wdata_o,
  output ex_pkg::reg_addr_t  fw_waddr_o,
  output logic               fw_we_o,
  output ex_pkg::data_t      jump_target_o,
  output logic               branch_decision_o,
  output logic               ex_ready_o,
  output logic               ex_valid_o,
  output ex_pkg::data_t      rd_data_o
);

  import ex_pkg::*;

  // Issue register outputs
  logic       iss_valid;
  alu_op_e    iss_alu_op;
  data_t      iss_op_a;
  data_t      iss_op_b;
  data_t      iss_op_c;
  logic       iss_mult_en;
  mult_mode_e iss_mult_mode;
  logic       iss_csr_access;
  data_t      iss_csr_rdata;
  logic       iss_branch;
  reg_addr_t  iss_waddr;
  logic       iss_we;

  // EX/WB to register file
  logic       wb_we;
  reg_addr_t  wb_waddr;
  data_t      wb_wdata;

  //////////////////////////////
  // ID/EX
  //////////////////////////////

  // Loads only while EX can accept
  ex_issue_reg u_issue_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .alu_op_i     (alu_op_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_c_i       (op_c_i),
    .mult_en_i    (mult_en_i),
    .mult_mode_i  (mult_mode_i),
    .csr_access_i (csr_access_i),
    .csr_rdata_i  (csr_rdata_i),
    .branch_i     (branch_i),
    .waddr_i      (waddr_i),
    .we_i         (we_i),
    .ex_ready_i   (ex_ready_o),
    .valid_o      (iss_valid),
    .alu_op_o     (iss_alu_op),
    .op_a_o       (iss_op_a),
    .op_b_o       (iss_op_b),
    .op_c_o       (iss_op_c),
    .mult_en_o    (iss_mult_en),
    .mult_mode_o  (iss_mult_mode),
    .csr_access_o (iss_csr_access),
    .csr_rdata_o  (iss_csr_rdata),
    .branch_o     (iss_branch),
    .waddr_o      (iss_waddr),
    .we_o         (iss_we)
  );

  // Execute plus EX/WB
  ex_stage #(.DATA_W(DATA_W)) u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (iss_valid),
    .alu_op_i          (iss_alu_op),
    .op_a_i            (iss_op_a),
    .op_b_i            (iss_op_b),
    .op_c_i            (iss_op_c),
    .mult_en_i         (iss_mult_en),
    .mult_mode_i       (iss_mult_mode),
    .csr_access_i      (iss_csr_access),
    .csr_rdata_i       (iss_csr_rdata),
    .branch_i          (iss_branch),
    .waddr_i           (iss_waddr),
    .we_i              (iss_we),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready_i),
    .fw_wdata_o        (fw_wdata_o),
    .fw_waddr_o        (fw_waddr_o),
    .fw_we_o           (fw_we_o),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .wb_we_o           (wb_we),
    .wb_waddr_o        (wb_waddr),
    .wb_wdata_o        (wb_wdata)
  );

  // Commit one edge after EX/WB
  wb_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (wb_we),
    .waddr_i (wb_waddr),
    .wdata_i (wb_wdata),
    .raddr_i (rd_addr_i),
    .rdata_o (rd_data_o)
  );

endmodule

`default_nettype wire

//--- hw/wb_regfile.sv
`default_nettype none

module wb_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we_i,
  input  ex_pkg::reg_addr_t waddr_i,
  input  ex_pkg::data_t     wdata_i,
  input  ex_pkg::reg_addr_t raddr_i,
  output ex_pkg::data_t     rdata_o
);

  import ex_pkg::*;

  // Flop-based storage, entry 0 never written
  data_t mem [NUM_REGS];

  logic  wr_allowed;

  // x0 is hardwired, writes to it are dropped
  assign wr_allowed = we_i && (waddr_i != '0);

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : rf_write
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (wr_allowed)
    begin
      mem[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Combinational read, x0 forced to zero
  always_comb
  begin
    if (raddr_i == '0)
      rdata_o = '0;
    else
      rdata_o = mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ex_subsys
OBJ=obj_dir

verilator --binary --timing --top-module "$TOP" -Mdir "$OBJ" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$("./$OBJ/V$TOP" 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# The run only counts as passed when the testbench says so
if grep -qx "=== PASS ===" <<< "$sim_out"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- testbench/tb_ex_subsys.sv
`default_nettype none

module tb_ex_subsys;

  timeunit 1ns;
  timeprecision 100ps;

  import ex_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int SAMPLE_DLY = 20;
  localparam int RESET_CYC  = 16;
  localparam int NUM_ROWS   = 22;
  // Upper bound on cycles spent per row
  localparam int ROW_CYC    = 10;

  // One operation of the test table
  // ctl is {mul_en, mac, csr_access, branch, we}
  // rdy is {lsu_ready, wb_ready} while stalled
  typedef struct packed {
    alu_op_e    op;
    logic [4:0] ctl;
    reg_addr_t  rd;
    logic       rnd;
    data_t      a;
    data_t      b;
    data_t      c;
    logic       chk;
    data_t      exp_w;
    logic [1:0] rdy;
    logic [1:0] stall;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  alu_op_e    alu_op;
  data_t      op_a;
  data_t      op_b;
  data_t      op_c;
  logic       mult_en;
  mult_mode_e mult_mode;
  logic       csr_access;
  data_t      csr_rdata;
  logic       branch;
  reg_addr_t  waddr;
  logic       we;
  logic       lsu_ready;
  logic       wb_ready;
  reg_addr_t  rd_addr;
  data_t      fw_wdata;
  reg_addr_t  fw_waddr;
  logic       fw_we;
  data_t      jump_target;
  logic       branch_decision;
  logic       ex_ready;
  logic       ex_valid;
  data_t      rd_data;

  row_t        rows [NUM_ROWS];
  // Shadow of the register file contents
  data_t       model_rf [NUM_REGS];
  logic [31:0] lfsr_state;

  ex_subsys_top #(.DATA_W(XLEN)) DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid_i        (in_valid),
    .alu_op_i          (alu_op),
    .op_a_i            (op_a),
    .op_b_i            (op_b),
    .op_c_i            (op_c),
    .mult_en_i         (mult_en),
    .mult_mode_i       (mult_mode),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .branch_i          (branch),
    .waddr_i           (waddr),
    .we_i              (we),
    .lsu_ready_i       (lsu_ready),
    .wb_ready_i        (wb_ready),
    .rd_addr_i         (rd_addr),
    .fw_wdata_o        (fw_wdata),
    .fw_waddr_o        (fw_waddr),
    .fw_we_o           (fw_we),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .rd_data_o         (rd_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Stimulus source
  //////////////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit of the word
  function automatic data_t draw_word();
    data_t w;
    w = '0;
    for (int i = 0; i < XLEN; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[XLEN-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic model_cmp(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic data_t model_alu(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      default: return {{(XLEN-1){1'b0}}, model_cmp(op, a, b)};
    endcase
  endfunction

  // Multiplier first, then CSR read data, then the ALU
  // CSR read data is driven as ~c
  function automatic data_t model_result(input alu_op_e op, input logic [4:0] ctl,
                                         input data_t a, input data_t b, input data_t c);
    if (ctl[4])
      return a * b + (ctl[3] ? c : '0);
    else if (ctl[2])
      return ~c;
    return model_alu(op, a, b);
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t ns %s expected %0d got %0d", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  //////////////////////////////
  // Test table
  //////////////////////////////

  // Columns: op, ctl, rd, rnd, a, b, c on the first line
  // then chk, exp_w, rdy, stall on the second
  task automatic fill_rows();
    rows[0]  = '{ALU_ADD, 5'b00001, 5'd1, 1'b0, 32'h5, 32'h7, 32'h0,
                 1'b1, 32'hc, 2'b11, 2'd0};
    rows[1]  = '{ALU_SUB, 5'b00001, 5'd2, 1'b0, 32'h3, 32'h5, 32'h0,
                 1'b1, 32'hffff_fffe, 2'b11, 2'd0};
    // LSU not ready for three cycles
    rows[2]  = '{ALU_AND, 5'b00001, 5'd3, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b01, 2'd3};
    // WB not ready for two cycles
    rows[3]  = '{ALU_OR, 5'b00001, 5'd4, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b10, 2'd2};
    rows[4]  = '{ALU_XOR, 5'b00001, 5'd5, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[5]  = '{ALU_SLL, 5'b00001, 5'd6, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[6]  = '{ALU_SRL, 5'b00001, 5'd7, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[7]  = '{ALU_SRA, 5'b00001, 5'd8, 1'b0, 32'h8000_0000, 32'h4, 32'h0,
                 1'b1, 32'hf800_0000, 2'b11, 2'd0};
    rows[8]  = '{ALU_SLT, 5'b00001, 5'd9, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[9]  = '{ALU_SLTU, 5'b00001, 5'd10, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[10] = '{ALU_ADD, 5'b10001, 5'd11, 1'b0, 32'h6, 32'h7, 32'h0,
                 1'b1, 32'h2a, 2'b11, 2'd0};
    // MAC with both ready levels low
    rows[11] = '{ALU_ADD, 5'b11001, 5'd12, 1'b0, 32'h3, 32'h4, 32'h100,
                 1'b1, 32'h10c, 2'b00, 2'd2};
    rows[12] = '{ALU_ADD, 5'b10001, 5'd13, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[13] = '{ALU_ADD, 5'b00101, 5'd14, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[14] = '{ALU_EQ, 5'b00010, 5'd3, 1'b0, 32'h1234, 32'h1234, 32'h80,
                 1'b1, 32'h1, 2'b11, 2'd0};
    rows[15] = '{ALU_NE, 5'b00010, 5'd4, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    // Branch under WB stall still retires
    rows[16] = '{ALU_LT, 5'b00010, 5'd5, 1'b0, 32'hffff_ffff, 32'h1, 32'h200,
                 1'b1, 32'h1, 2'b10, 2'd2};
    rows[17] = '{ALU_GE, 5'b00010, 5'd6, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[18] = '{ALU_LTU, 5'b00010, 5'd7, 1'b0, 32'hffff_ffff, 32'h1, 32'h300,
                 1'b1, 32'h0, 2'b11, 2'd0};
    rows[19] = '{ALU_GEU, 5'b00010, 5'd8, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b01, 2'd3};
    // Write to x0 is dropped
    rows[20] = '{ALU_ADD, 5'b00001, 5'd0, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
    rows[21] = '{ALU_XOR, 5'b00001, 5'd1, 1'b1, 32'h0, 32'h0, 32'h0,
                 1'b0, 32'h0, 2'b11, 2'd0};
  endtask

  //////////////////////////////
  // Row sequencing
  //////////////////////////////

  task automatic drive_op(input row_t r, input data_t a, input data_t b, input data_t c);
    in_valid   = 1'b1;
    alu_op     = r.op;
    op_a       = a;
    op_b       = b;
    op_c       = c;
    mult_en    = r.ctl[4];
    mult_mode  = r.ctl[3] ? MULT_MAC : MULT_MUL;
    csr_access = r.ctl[2];
    // CSR read data kept apart from op_c
    csr_rdata  = ~c;
    branch     = r.ctl[1];
    we         = r.ctl[0];
    waddr      = r.rd;
    rd_addr    = r.rd;
    lsu_ready  = 1'b1;
    wb_ready   = 1'b1;
  endtask

  task automatic run_row(input int idx);
    row_t       r;
    data_t      a;
    data_t      b;
    data_t      c;
    data_t      exp_w;
    logic       exp_cmp;
    logic [1:0] rdy;
    int         k;
    r = rows[idx];
    a = r.a;
    b = r.b;
    c = r.c;
    if (r.rnd)
    begin
      a = draw_word();
      b = draw_word();
      c = draw_word();
    end
    exp_cmp = model_cmp(r.op, a, b);
    exp_w   = r.chk ? r.exp_w : model_result(r.op, r.ctl, a, b, c);
    rdy     = (r.stall != 2'd0) ? r.rdy : 2'b11;

    // Present the operation with EX free
    @(posedge clk);
    #(DRIVE_DLY);
    drive_op(r, a, b, c);
    #(SAMPLE_DLY - DRIVE_DLY);
    check_bit("ex_ready_o", 1'b1, ex_ready);

    // Accepted on this edge, EX works on it in the next cycle
    @(posedge clk);
    #(DRIVE_DLY);
    in_valid  = 1'b0;
    lsu_ready = rdy[1];
    wb_ready  = rdy[0];
    #(SAMPLE_DLY - DRIVE_DLY);
    check_data("fw_wdata_o", exp_w, fw_wdata);
    check_addr("fw_waddr_o", r.rd, fw_waddr);
    check_bit("fw_we_o", r.ctl[0], fw_we);
    check_bit("ex_valid_o", rdy[1] & rdy[0], ex_valid);
    check_bit("ex_ready_o", (rdy[1] & rdy[0]) | r.ctl[1], ex_ready);
    if (r.ctl[1])
    begin
      check_bit("branch_decision_o", exp_cmp, branch_decision);
      check_data("jump_target_o", c, jump_target);
    end

    // Remaining stall cycles hold the operation in ID/EX
    for (k = 1; k < int'(r.stall); k++)
    begin
      @(posedge clk);
      #(SAMPLE_DLY);
      check_bit("ex_valid_o", 1'b0, ex_valid);
      check_bit("ex_ready_o", 1'b0, ex_ready);
      check_data("rd_data_o", model_rf[r.rd], rd_data);
      if (!r.ctl[1])
        check_data("fw_wdata_o", exp_w, fw_wdata);
    end

    // Release the stall, still nothing committed
    if (r.stall != 2'd0)
    begin
      @(posedge clk);
      #(DRIVE_DLY);
      lsu_ready = 1'b1;
      wb_ready  = 1'b1;
      #(SAMPLE_DLY - DRIVE_DLY);
      check_bit("ex_valid_o", 1'b1, ex_valid);
      check_data("rd_data_o", model_rf[r.rd], rd_data);
    end

    // EX/WB capture, then the register file write
    if (r.ctl[0] && r.rd != '0)
      model_rf[r.rd] = exp_w;
    repeat (2) @(posedge clk);
    #(SAMPLE_DLY);
    check_data("rd_data_o", model_rf[r.rd], rd_data);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin : main
    int i;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    alu_op     = ALU_ADD;
    op_a       = '0;
    op_b       = '0;
    op_c       = '0;
    mult_en    = 1'b0;
    mult_mode  = MULT_MUL;
    csr_access = 1'b0;
    csr_rdata  = '0;
    branch     = 1'b0;
    waddr      = '0;
    we         = 1'b0;
    lsu_ready  = 1'b1;
    wb_ready   = 1'b1;
    rd_addr    = '0;
    lfsr_state = 32'h6a32_9676;
    for (i = 0; i < NUM_REGS; i++)
      model_rf[i] = '0;
    fill_rows();

    repeat (RESET_CYC) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    for (i = 0; i < NUM_ROWS; i++)
      run_row(i);

    $display("=== PASS ===");
    $finish;
  end

  // Bound on the whole run
  initial
  begin : watchdog
    #((NUM_ROWS * ROW_CYC + RESET_CYC) * CLK_PERIOD);
    $display("Timeout: the test rows did not finish in the expected time");
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire
